//--- sim/program.hex
// one 32-bit instruction word per line, in hex
// line n holds the word at byte address 4*n, text after // is the disassembly
00000513 // 0x00 addi a0, x0, 0x00
00400513 // 0x04 addi a0, x0, 0x04
00800513 // 0x08 addi a0, x0, 0x08
00c00513 // 0x0c addi a0, x0, 0x0c
01000513 // 0x10 addi a0, x0, 0x10
0140006f // 0x14 jal x0, +0x14 forward to 0x28
fff00f93 // 0x18 never executed
fff00f93 // 0x1c never executed
02000513 // 0x20 addi a0, x0, 0x20
0180006f // 0x24 jal x0, +0x18 forward to 0x3c
02800513 // 0x28 addi a0, x0, 0x28
02c00513 // 0x2c addi a0, x0, 0x2c
03000513 // 0x30 addi a0, x0, 0x30
fedff06f // 0x34 jal x0, -0x14 back to 0x20
fff00f93 // 0x38 never executed
03c00513 // 0x3c addi a0, x0, 0x3c
04000513 // 0x40 addi a0, x0, 0x40
04400513 // 0x44 addi a0, x0, 0x44
00208c63 // 0x48 beq x1, x2, +0x18 to 0x60
04c00513 // 0x4c addi a0, x0, 0x4c
05000513 // 0x50 addi a0, x0, 0x50
05400513 // 0x54 addi a0, x0, 0x54
05800513 // 0x58 addi a0, x0, 0x58
05c00513 // 0x5c addi a0, x0, 0x5c
06000513 // 0x60 addi a0, x0, 0x60
06400513 // 0x64 addi a0, x0, 0x64
06800513 // 0x68 addi a0, x0, 0x68
06c00513 // 0x6c addi a0, x0, 0x6c
07000513 // 0x70 addi a0, x0, 0x70
07400513 // 0x74 addi a0, x0, 0x74
07800513 // 0x78 addi a0, x0, 0x78
f85ff06f // 0x7c jal x0, -0x7c back to 0x00

//--- list.f
hdl/fetch_pkg.sv
hdl/sync_queue.sv
hdl/branch_predictor.sv
hdl/fetch_unit.sv
hdl/inst_mem.sv
hdl/fetch_top.sv
sim/tb_fetch.sv

//--- sim/tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

    // test lengths in accepted outputs
    localparam int n_straight = 5;
    localparam int n_jal = 29;
    localparam int n_redirect = 20;
    localparam int n_predict = 24;
    localparam int n_random = 60;
    localparam int n_ids = 12;
    localparam int planned_outputs = n_straight + n_jal + n_redirect + n_predict
        + n_random + n_ids;
    localparam int timeout_cycles = planned_outputs * 20;

    logic clk;
    logic reset;
    logic redirect_valid;
    logic [fetch_pkg::addr_w-1:0] redirect_addr;
    logic update_valid;
    logic [fetch_pkg::addr_w-1:0] update_pc;
    logic update_taken;
    logic [fetch_pkg::addr_w-1:0] update_target;
    logic out_valid;
    logic [fetch_pkg::addr_w-1:0] out_addr;
    logic [fetch_pkg::inst_w-1:0] out_inst;
    logic [fetch_pkg::iid_w-1:0] out_id;
    logic out_ready;

    // reference copy of the program and of the predictor state
    logic [31:0] rom_model [fetch_pkg::mem_words];
    int pred_ctr [fetch_pkg::pred_entries];
    logic pred_valid [fetch_pkg::pred_entries];
    logic [31:0] pred_target [fetch_pkg::pred_entries];
    logic [31:0] pred_tag [fetch_pkg::pred_entries];

    logic [31:0] exp_addr;
    logic [31:0] exp_inst;
    logic [fetch_pkg::iid_w-1:0] last_id;
    logic [fetch_pkg::iid_w-1:0] id_gap;
    logic id_seen;
    logic accept;
    logic [5:0] upd_idx;
    logic [31:0] rng;
    int low_left;
    int accepted = 0;
    int errors = 0;
    int cycles = 0;
    int test_num = 0;
    int test_out_start = 0;
    int test_err_start = 0;

    fetch_top DUT (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_taken   (update_taken),
        .update_target  (update_target),
        .out_valid      (out_valid),
        .out_addr       (out_addr),
        .out_inst       (out_inst),
        .out_id         (out_id),
        .out_ready      (out_ready)
    );

    always #20 clk = ~clk;

    assign accept = out_valid && out_ready;
    assign upd_idx = update_pc[7:2];
    // word index of the 256-word rom from bits 9:2
    assign exp_inst = rom_model[exp_addr[9:2]];
    // ids wrap at 8 bits and are compared by forward distance
    assign id_gap = out_id - last_id;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rv32 J-type immediate assembled field by field
    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        logic [20:0] imm;
        imm[20] = w[31];
        imm[10:1] = w[30:21];
        imm[11] = w[20];
        imm[19:12] = w[19:12];
        imm[0] = 1'b0;
        return 32'($signed(imm));
    endfunction

    // address that follows a on the predicted path
    function automatic logic [31:0] model_next(input logic [31:0] a);
        logic [31:0] word;
        logic [5:0] idx;
        word = rom_model[a[9:2]];
        idx = a[7:2];
        if (word[6:0] == fetch_pkg::OP_JAL) begin
            return a + jal_offset(word);
        end
        if (pred_valid[idx] && pred_tag[idx][31:8] == a[31:8] && pred_ctr[idx] >= 2) begin
            return pred_target[idx];
        end
        return a + 32'd4;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            exp_addr <= 32'h0;
            id_seen <= 1'b0;
            last_id <= '0;
            for (int i = 0; i < fetch_pkg::pred_entries; i++) begin
                pred_ctr[i] <= 1;
                pred_valid[i] <= 1'b0;
            end
        end else begin
            if (update_valid && update_taken) begin
                pred_ctr[upd_idx] <= (pred_ctr[upd_idx] == 3) ? 3 : pred_ctr[upd_idx] + 1;
                pred_valid[upd_idx] <= 1'b1;
                pred_target[upd_idx] <= update_target;
                pred_tag[upd_idx] <= update_pc;
            end else if (update_valid) begin
                pred_ctr[upd_idx] <= (pred_ctr[upd_idx] == 0) ? 0 : pred_ctr[upd_idx] - 1;
            end
            if (redirect_valid) begin
                exp_addr <= redirect_addr;
            end else if (accept) begin
                exp_addr <= model_next(exp_addr);
                last_id <= out_id;
                id_seen <= 1'b1;
                accepted <= accepted + 1;
            end
        end
    end

    a_addr: assert property (@(posedge clk) disable iff (reset) accept |-> out_addr == exp_addr)
        else begin
            $display("[FAIL] out_addr got %h expected %h", $sampled(out_addr), $sampled(exp_addr));
            errors++;
        end

    a_inst: assert property (@(posedge clk) disable iff (reset) accept |-> out_inst == exp_inst)
        else begin
            $display("[FAIL] out_inst got %h expected %h", $sampled(out_inst), $sampled(exp_inst));
            errors++;
        end

    a_id: assert property (@(posedge clk) disable iff (reset)
        accept && id_seen |-> id_gap != 0 && id_gap < 8'd128)
        else begin
            $display("[FAIL] out_id got %h after %h", $sampled(out_id), $sampled(last_id));
            errors++;
        end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect_valid
        |=> out_valid && $stable({out_addr, out_inst, out_id}))
        else begin
            $display("output item changed or vanished while out_ready was low");
            errors++;
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: %0d outputs accepted in %0d cycles", accepted, cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic run_outputs(input int n, input bit random_ready);
        int target;
        target = accepted + n;
        while (accepted < target) begin
            @(posedge clk);
            if (!random_ready) begin
                out_ready <= 1'b1;
            end else if (low_left > 0) begin
                out_ready <= 1'b0;
                low_left--;
            end else begin
                rng = lcg_step(rng);
                // now and then a long stall that fills the queue
                if (rng[31:27] == 5'd0) begin
                    low_left = 20 + rng[4:0];
                end
                out_ready <= rng[16];
            end
        end
    endtask

    task automatic stall_output(input int n);
        repeat (n) begin
            @(posedge clk);
            out_ready <= 1'b0;
        end
    endtask

    task automatic send_update(input logic [31:0] pc, input logic taken, input logic [31:0] tgt);
        @(posedge clk);
        out_ready <= 1'b0;
        update_valid <= 1'b1;
        update_pc <= pc;
        update_taken <= taken;
        update_target <= tgt;
        @(posedge clk);
        update_valid <= 1'b0;
    endtask

    task automatic send_redirect(input logic [31:0] addr);
        @(posedge clk);
        out_ready <= 1'b0;
        redirect_valid <= 1'b1;
        redirect_addr <= addr;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        test_num++;
        $display("test %0d %s: %0d outputs, %0d errors", test_num, name,
                 accepted - test_out_start, errors - test_err_start);
        test_out_start = accepted;
        test_err_start = errors;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        redirect_valid = 1'b0;
        redirect_addr = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_taken = 1'b0;
        update_target = '0;
        out_ready = 1'b0;
        rng = 32'h557bfc64;
        low_left = 0;
        $readmemh("sim/program.hex", rom_model);

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        a_reset_empty: assert (out_valid == 1'b0)
            else begin
                $display("[FAIL] out_valid got %h expected 0 after reset", out_valid);
                errors++;
            end

        run_outputs(n_straight, 1'b0);
        finish_test("straight line");
        run_outputs(n_jal, 1'b0);
        finish_test("forward and backward jal");

        // flush a queue that holds items
        stall_output(12);
        send_redirect(32'h44);
        run_outputs(n_redirect, 1'b0);
        finish_test("redirect");

        // branch at 0x48 trained taken and then back to not taken
        send_update(32'h48, 1'b1, 32'h60);
        send_redirect(32'h3c);
        run_outputs(n_predict / 2, 1'b0);
        send_update(32'h48, 1'b0, 32'h0);
        send_update(32'h48, 1'b0, 32'h0);
        send_redirect(32'h3c);
        run_outputs(n_predict / 2, 1'b0);
        finish_test("predictor train and untrain");

        run_outputs(n_random, 1'b1);
        finish_test("random back-pressure");

        send_redirect(32'h7c);
        run_outputs(n_ids, 1'b1);
        finish_test("ids after redirect into jal");

        repeat (2) @(posedge clk);
        $display("tests %0d, outputs %0d, errors %0d", test_num, accepted, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0] redirect_addr,

    input  logic                         update_valid,
    input  logic [fetch_pkg::addr_w-1:0] update_pc,
    input  logic                         update_taken,
    input  logic [fetch_pkg::addr_w-1:0] update_target,

    output logic                         out_valid,
    output logic [fetch_pkg::addr_w-1:0] out_addr,
    output logic [fetch_pkg::inst_w-1:0] out_inst,
    output logic [fetch_pkg::iid_w-1:0]  out_id,
    input  logic                         out_ready
);

    // instruction memory bus
    logic                         mem_req_valid;
    logic                         mem_req_ready;
    logic [fetch_pkg::addr_w-1:0] mem_req_addr;
    logic                         mem_resp_valid;
    logic [fetch_pkg::addr_w-1:0] mem_resp_addr;
    logic [fetch_pkg::inst_w-1:0] mem_resp_inst;

    fetch_unit u_fetch (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_addr  (mem_resp_addr),
        .mem_resp_inst  (mem_resp_inst),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_taken   (update_taken),
        .update_target  (update_target),
        .out_valid      (out_valid),
        .out_addr       (out_addr),
        .out_inst       (out_inst),
        .out_id         (out_id),
        .out_ready      (out_ready)
    );

    inst_mem u_imem (
        .clk            (clk),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_addr  (mem_resp_addr),
        .mem_resp_inst  (mem_resp_inst)
    );

endmodule

`default_nettype wire

//--- hdl/inst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module inst_mem (
    input  logic                         clk,

    input  logic                         mem_req_valid,
    input  logic [fetch_pkg::addr_w-1:0] mem_req_addr,
    output logic                         mem_req_ready,

    output logic                         mem_resp_valid,
    output logic [fetch_pkg::addr_w-1:0] mem_resp_addr,
    output logic [fetch_pkg::inst_w-1:0] mem_resp_inst
);

    logic [fetch_pkg::inst_w-1:0] rom [fetch_pkg::mem_words];
    logic [$clog2(fetch_pkg::mem_words)-1:0] word_idx;
    logic resp_valid_q = 1'b0;

    initial begin
        $readmemh("sim/program.hex", rom);
    end

    // never stalls
    assign mem_req_ready = 1'b1;

    // word addressed so the low two bits are ignored
    assign word_idx = mem_req_addr[$clog2(fetch_pkg::mem_words)+1:2];

    always_ff @(posedge clk) begin
        resp_valid_q <= mem_req_valid && mem_req_ready;
        if (mem_req_valid && mem_req_ready) begin
            mem_resp_addr <= mem_req_addr;
            mem_resp_inst <= rom[word_idx];
        end
    end

    assign mem_resp_valid = resp_valid_q;

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0] redirect_addr,

    output logic                         mem_req_valid,
    output logic [fetch_pkg::addr_w-1:0] mem_req_addr,
    input  logic                         mem_req_ready,
    input  logic                         mem_resp_valid,
    input  logic [fetch_pkg::addr_w-1:0] mem_resp_addr,
    input  logic [fetch_pkg::inst_w-1:0] mem_resp_inst,

    input  logic                         update_valid,
    input  logic [fetch_pkg::addr_w-1:0] update_pc,
    input  logic                         update_taken,
    input  logic [fetch_pkg::addr_w-1:0] update_target,

    output logic                         out_valid,
    output logic [fetch_pkg::addr_w-1:0] out_addr,
    output logic [fetch_pkg::inst_w-1:0] out_inst,
    output logic [fetch_pkg::iid_w-1:0]  out_id,
    input  logic                         out_ready
);

    fetch_pkg::fetch_state_e state_q;

    logic [fetch_pkg::addr_w-1:0] pc_q;
    logic [fetch_pkg::addr_w-1:0] req_addr_q;
    logic [fetch_pkg::iid_w-1:0] iid_q;
    logic [fetch_pkg::iid_w-1:0] req_id_q;

    logic last_valid_q;
    logic [fetch_pkg::addr_w-1:0] last_addr_q;
    logic [fetch_pkg::inst_w-1:0] last_inst_q;

    fetch_pkg::opcode_e last_opcode;
    logic [fetch_pkg::addr_w-1:0] imm_j;
    logic [fetch_pkg::addr_w-1:0] jal_target;
    logic last_is_jal;
    logic steer;
    logic jal_drop;

    logic [fetch_pkg::addr_w-1:0] fetch_addr;
    logic [fetch_pkg::addr_w-1:0] pred_next_pc;
    logic req_fire;

    logic q_write;
    logic q_write_ready_next;
    logic [fetch_pkg::addr_w+fetch_pkg::inst_w+fetch_pkg::iid_w-1:0] q_write_data;
    logic [fetch_pkg::addr_w+fetch_pkg::inst_w+fetch_pkg::iid_w-1:0] q_read_data;

    // jal lookahead on the most recently fetched word
    assign last_opcode = fetch_pkg::opcode_e'(last_inst_q[6:0]);
    assign last_is_jal = last_valid_q && (last_opcode == fetch_pkg::OP_JAL);
    assign imm_j = {{11{last_inst_q[31]}}, last_inst_q[31], last_inst_q[19:12],
                    last_inst_q[20], last_inst_q[30:21], 1'b0};
    assign jal_target = last_addr_q + imm_j;

    // nothing issued since the jal or the issued fetch went the wrong way
    assign steer = last_is_jal
        && ((state_q == fetch_pkg::FETCH_IDLE) || (req_addr_q != jal_target));
    assign jal_drop = (state_q == fetch_pkg::FETCH_WAIT) && steer;

    // redirect wins over the lookahead
    always_comb begin
        if (redirect_valid) begin
            fetch_addr = redirect_addr;
        end else if (steer) begin
            fetch_addr = jal_target;
        end else begin
            fetch_addr = pc_q;
        end
    end

    assign mem_req_valid = q_write_ready_next;
    assign mem_req_addr = fetch_addr;
    assign req_fire = mem_req_valid && mem_req_ready;

    assign q_write = (state_q == fetch_pkg::FETCH_WAIT) && mem_resp_valid
        && !redirect_valid && !jal_drop;
    assign q_write_data = {mem_resp_addr, mem_resp_inst, req_id_q};
    assign {out_addr, out_inst, out_id} = q_read_data;

    branch_predictor u_predictor (
        .clk           (clk),
        .reset         (reset),
        .pc            (fetch_addr),
        .next_pc       (pred_next_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    sync_queue #(
        .depth (fetch_pkg::queue_depth),
        .width (fetch_pkg::addr_w + fetch_pkg::inst_w + fetch_pkg::iid_w)
    ) u_queue (
        .clk              (clk),
        .reset            (reset),
        .flush            (redirect_valid),
        .write_valid      (q_write),
        .write_data       (q_write_data),
        .write_ready      (),
        .write_ready_next (q_write_ready_next),
        .read_ready       (out_ready),
        .read_valid       (out_valid),
        .read_data        (q_read_data)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= fetch_pkg::FETCH_IDLE;
            pc_q <= fetch_pkg::reset_pc;
            iid_q <= fetch_pkg::reset_iid;
            last_valid_q <= 1'b0;
        end else begin
            if (req_fire) begin
                state_q <= fetch_pkg::FETCH_WAIT;
                pc_q <= pred_next_pc;
                iid_q <= iid_q + 1'b1;
            end else begin
                // hold the steered address until the queue has room
                state_q <= fetch_pkg::FETCH_IDLE;
                pc_q <= fetch_addr;
            end
            if (q_write) begin
                last_valid_q <= 1'b1;
            end else if (redirect_valid || steer) begin
                last_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_addr_q <= fetch_addr;
            req_id_q <= iid_q;
        end
        if (q_write) begin
            last_addr_q <= mem_resp_addr;
            last_inst_q <= mem_resp_inst;
        end
    end

    // memory answers the outstanding request exactly one cycle later
    a_resp_matches: assert property (@(posedge clk) disable iff (reset)
        state_q == fetch_pkg::FETCH_WAIT |-> mem_resp_valid && mem_resp_addr == req_addr_q)
        else $error("response does not match outstanding request");

endmodule

`default_nettype wire

//--- hdl/branch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predictor (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [fetch_pkg::addr_w-1:0]  pc,
    output logic [fetch_pkg::addr_w-1:0]  next_pc,

    input  logic                          update_valid,
    input  logic [fetch_pkg::addr_w-1:0]  update_pc,
    input  logic                          update_taken,
    input  logic [fetch_pkg::addr_w-1:0]  update_target
);

    fetch_pkg::ctr_e ctr_q [fetch_pkg::pred_entries];
    logic tgt_valid_q [fetch_pkg::pred_entries];
    logic [fetch_pkg::addr_w-1:0] target_q [fetch_pkg::pred_entries];
    logic [fetch_pkg::addr_w-1:fetch_pkg::pred_idx_w+2] tag_q [fetch_pkg::pred_entries];

    logic [fetch_pkg::pred_idx_w-1:0] rd_idx;
    logic [fetch_pkg::pred_idx_w-1:0] wr_idx;
    logic hit;
    logic predict_taken;

    function automatic fetch_pkg::ctr_e ctr_step(input fetch_pkg::ctr_e ctr, input logic taken);
        fetch_pkg::ctr_e result;
        result = ctr;
        case (ctr)
            fetch_pkg::STRONG_NT: result = taken ? fetch_pkg::WEAK_NT : fetch_pkg::STRONG_NT;
            fetch_pkg::WEAK_NT:   result = taken ? fetch_pkg::WEAK_T : fetch_pkg::STRONG_NT;
            fetch_pkg::WEAK_T:    result = taken ? fetch_pkg::STRONG_T : fetch_pkg::WEAK_NT;
            fetch_pkg::STRONG_T:  result = taken ? fetch_pkg::STRONG_T : fetch_pkg::WEAK_T;
            default:              result = fetch_pkg::reset_ctr;
        endcase
        return result;
    endfunction

    assign rd_idx = pc[fetch_pkg::pred_idx_w+1:2];
    assign wr_idx = update_pc[fetch_pkg::pred_idx_w+1:2];

    // lookup is purely combinational
    assign hit = tgt_valid_q[rd_idx]
        && (tag_q[rd_idx] == pc[fetch_pkg::addr_w-1:fetch_pkg::pred_idx_w+2]);
    assign predict_taken = (ctr_q[rd_idx] inside {fetch_pkg::WEAK_T, fetch_pkg::STRONG_T});

    assign next_pc = (hit && predict_taken) ? target_q[rd_idx]
                                            : pc + fetch_pkg::addr_w'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < fetch_pkg::pred_entries; i++) begin
                ctr_q[i] <= fetch_pkg::reset_ctr;
                tgt_valid_q[i] <= 1'b0;
            end
        end else if (update_valid) begin
            ctr_q[wr_idx] <= ctr_step(ctr_q[wr_idx], update_taken);
            if (update_taken) begin
                tgt_valid_q[wr_idx] <= 1'b1;
            end
        end
    end

    // target and tag only move on a taken update
    always_ff @(posedge clk) begin
        if (update_valid && update_taken) begin
            target_q[wr_idx] <= update_target;
            tag_q[wr_idx] <= update_pc[fetch_pkg::addr_w-1:fetch_pkg::pred_idx_w+2];
        end
    end

endmodule

`default_nettype wire

//--- hdl/sync_queue.sv
`timescale 1ns/1ns
`default_nettype none

module sync_queue #(
    parameter int depth = 16,
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,

    input  logic             write_valid,
    input  logic [width-1:0] write_data,
    output logic             write_ready,
    output logic             write_ready_next,

    input  logic             read_ready,
    output logic             read_valid,
    output logic [width-1:0] read_data
);

    typedef logic [$clog2(depth)-1:0] ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    logic [width-1:0] mem [depth];

    ptr_t rd_ptr_q;
    ptr_t wr_ptr_q;
    cnt_t count_q;
    cnt_t count_next;
    logic do_write;
    logic do_read;

    function automatic ptr_t ptr_inc(input ptr_t ptr);
        if (ptr == ptr_t'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign write_ready = (count_q != cnt_t'(depth));
    assign read_valid = (count_q != '0);
    assign read_data = mem[rd_ptr_q];

    assign do_write = write_valid && write_ready && !flush;
    assign do_read = read_valid && read_ready;

    // occupancy after this cycle's traffic
    always_comb begin
        count_next = count_q;
        if (flush) begin
            count_next = '0;
        end else if (do_write && !do_read) begin
            count_next = count_q + 1'b1;
        end else if (!do_write && do_read) begin
            count_next = count_q - 1'b1;
        end
    end

    // room for a write issued one cycle from now
    assign write_ready_next = (count_next != cnt_t'(depth));

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_read) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
        end
        count_q <= reset ? '0 : count_next;
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr_q] <= write_data;
        end
    end

    // the producer sizes its requests by write_ready_next
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        write_valid |-> write_ready)
        else $error("write into a full queue");

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int inst_w = 32;
    localparam int iid_w = 8;

    // output queue entries
    localparam int queue_depth = 16;

    // predictor geometry with the index from address bits 7:2
    localparam int pred_entries = 64;
    localparam int pred_idx_w = 6;

    // instruction ROM size in words
    localparam int mem_words = 256;

    // rv32 major opcodes of which only jal steers fetch
    typedef enum logic [6:0] {
        OP_JAL       = 7'b110_1111,
        OP_JALR      = 7'b110_0111,
        OP_BRANCH    = 7'b110_0011,
        OP_OTHER_ALU = 7'b001_0011
    } opcode_e;

    // FETCH_WAIT means one request is outstanding
    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

    // two-bit saturating counter
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_e;

    // reset values
    localparam logic [addr_w-1:0] reset_pc = '0;
    localparam logic [iid_w-1:0] reset_iid = '0;
    localparam ctr_e reset_ctr = WEAK_NT;

endpackage

`default_nettype wire
